//--- add_unit.sv
`timescale 1ns/1ns
`include "idc_defs.svh"

module add_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  idc_pkg::op_type_t  op_type,
  input  idc_pkg::reg_addr_t src1_addr,
  input  idc_pkg::reg_addr_t src2_addr,
  input  idc_pkg::reg_addr_t dst_addr,
  input  idc_pkg::data_t     imm,
  input  idc_pkg::pc_t       pc,
  output idc_pkg::reg_addr_t rd_addr1,
  output idc_pkg::reg_addr_t rd_addr2,
  input  idc_pkg::data_t     rd_data1,
  input  idc_pkg::data_t     rd_data2,
  output logic               wr_en,
  output idc_pkg::reg_addr_t wr_addr,
  output idc_pkg::data_t     wr_data,
  output idc_pkg::pc_t       next_pc,
  output logic               busy,
  output logic               done
);

  idc_pkg::unit_state_t state;
  idc_pkg::op_type_t    op_type_q;
  idc_pkg::reg_addr_t   src1_q;
  idc_pkg::reg_addr_t   src2_q;
  idc_pkg::reg_addr_t   dst_q;
  idc_pkg::data_t       imm_q;
  idc_pkg::pc_t         pc_q;
  idc_pkg::data_t       operand_b;
  idc_pkg::data_t       sum_q;

  // I type takes the immediate, every other type reads src2
  assign operand_b = (op_type_q == `IDC_OPTYPE_I) ? imm_q : rd_data2;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idc_pkg::U_IDLE;
    end else begin
      case (state)
        idc_pkg::U_IDLE: if (start) state <= idc_pkg::U_EXEC;
        idc_pkg::U_EXEC: state <= idc_pkg::U_DONE; // Single cycle add
        idc_pkg::U_DONE: state <= idc_pkg::U_IDLE;
        default:         state <= idc_pkg::U_IDLE;
      endcase
    end
  end

  // Operand fields and result
  always_ff @(posedge clk) begin
    if (start) begin
      op_type_q <= op_type;
      src1_q    <= src1_addr;
      src2_q    <= src2_addr;
      dst_q     <= dst_addr;
      imm_q     <= imm;
      pc_q      <= pc;
    end
    if (state == idc_pkg::U_EXEC) begin
      sum_q <= rd_data1 + operand_b; // Wraps modulo 2^32
    end
  end

  assign rd_addr1 = src1_q;
  assign rd_addr2 = src2_q;

  // Write-back happens in the done cycle
  assign wr_en   = (state == idc_pkg::U_DONE);
  assign wr_addr = dst_q;
  assign wr_data = sum_q;
  assign next_pc = pc_q + 5'd1;          // Wraps at 32
  assign busy    = (state == idc_pkg::U_EXEC);
  assign done    = (state == idc_pkg::U_DONE);

  // The decode controller only dispatches to an idle unit
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (rst)
    start |-> !busy
  ) else $error("add_unit: start while busy");

endmodule

//--- decode_ctrl.sv
`timescale 1ns/1ns
`include "idc_defs.svh"

module decode_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  idc_pkg::instr_t    instruction,
  output logic               busy,
  output logic               done,
  output logic               fetch_stage_enable,
  output idc_pkg::pc_t       next_pc_to_cpu,
  output logic               start_add,
  output logic               start_mult,
  output idc_pkg::op_type_t  op_type,
  output idc_pkg::reg_addr_t src1_addr,
  output idc_pkg::reg_addr_t src2_addr,
  output idc_pkg::reg_addr_t dst_addr,
  output idc_pkg::data_t     imm,
  output idc_pkg::pc_t       pc,
  input  logic               add_busy,
  input  logic               add_done,
  input  logic               mult_busy,
  input  logic               mult_done,
  input  idc_pkg::pc_t       add_next_pc,
  input  idc_pkg::pc_t       mult_next_pc,
  input  idc_pkg::reg_addr_t add_rd_addr1,
  input  idc_pkg::reg_addr_t add_rd_addr2,
  input  idc_pkg::reg_addr_t mult_rd_addr1,
  input  idc_pkg::reg_addr_t mult_rd_addr2,
  input  logic               add_wr_en,
  input  logic               mult_wr_en,
  input  idc_pkg::reg_addr_t add_wr_addr,
  input  idc_pkg::reg_addr_t mult_wr_addr,
  input  idc_pkg::data_t     add_wr_data,
  input  idc_pkg::data_t     mult_wr_data,
  output idc_pkg::reg_addr_t rf_rd_addr1,
  output idc_pkg::reg_addr_t rf_rd_addr2,
  output idc_pkg::reg_addr_t rf_wr_addr,
  output logic               rf_wr_en,
  output idc_pkg::data_t     rf_wr_data
);

  idc_pkg::ctrl_state_t state;
  idc_pkg::unit_sel_t   sel;        // Owner of the register file ports
  logic                 op_known;   // Opcode maps to a unit
  idc_pkg::opcode_t     opcode_in;
  logic                 unit_done;
  logic                 unit_busy;
  idc_pkg::pc_t         unit_next_pc;

  assign opcode_in = instruction[`IDC_OPCODE_HI:`IDC_OPCODE_LO];

  // Status of whichever unit is active
  assign unit_done    = (sel == idc_pkg::SEL_MULT) ? mult_done    : add_done;
  assign unit_busy    = (sel == idc_pkg::SEL_MULT) ? mult_busy    : add_busy;
  assign unit_next_pc = (sel == idc_pkg::SEL_MULT) ? mult_next_pc : add_next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= idc_pkg::IDLE;
      sel                <= idc_pkg::SEL_ADD;
      op_known           <= 1'b0;
      busy               <= 1'b0;
      done               <= 1'b0;
      fetch_stage_enable <= 1'b0;
      next_pc_to_cpu     <= '0;
    end else begin
      case (state)
        idc_pkg::IDLE: begin
          if (start) begin                       // Only sampled here, so ignored while busy
            busy               <= 1'b1;
            done               <= 1'b0;
            fetch_stage_enable <= 1'b0;          // CPU polls this
            sel      <= (opcode_in == `IDC_OP_MULT) ? idc_pkg::SEL_MULT : idc_pkg::SEL_ADD;
            op_known <= (opcode_in == `IDC_OP_ADD) || (opcode_in == `IDC_OP_MULT);
            state    <= idc_pkg::DISPATCH;
          end
        end
        idc_pkg::DISPATCH: begin
          if (!op_known) begin
            // Unknown opcode retires at once and writes nothing
            busy               <= 1'b0;
            done               <= 1'b1;
            fetch_stage_enable <= 1'b1;
            next_pc_to_cpu     <= pc + 5'd1;
            state              <= idc_pkg::IDLE;
          end else begin
            state <= idc_pkg::WAIT_UNIT;         // Start pulse goes out this cycle
          end
        end
        idc_pkg::WAIT_UNIT: begin
          if (unit_done) begin
            busy               <= 1'b0;
            done               <= 1'b1;
            fetch_stage_enable <= 1'b1;
            next_pc_to_cpu     <= unit_next_pc;
            state              <= idc_pkg::IDLE;
          end
        end
        default: state <= idc_pkg::IDLE;
      endcase
    end
  end

  // Instruction fields held for the whole operation
  always_ff @(posedge clk) begin
    if (state == idc_pkg::IDLE && start) begin
      op_type   <= instruction[`IDC_OPTYPE_HI:`IDC_OPTYPE_LO];
      dst_addr  <= instruction[`IDC_DST_HI:`IDC_DST_LO];
      src1_addr <= instruction[`IDC_SRC1_HI:`IDC_SRC1_LO];
      src2_addr <= instruction[`IDC_SRC2_HI:`IDC_SRC2_LO];
      pc        <= instruction[`IDC_PC_HI:`IDC_PC_LO];
      imm       <= instruction[`IDC_IMM_HI:`IDC_IMM_LO];
    end
  end

  // One cycle start to the chosen unit
  assign start_add  = (state == idc_pkg::DISPATCH) && op_known && (sel == idc_pkg::SEL_ADD);
  assign start_mult = (state == idc_pkg::DISPATCH) && op_known && (sel == idc_pkg::SEL_MULT);

  // Register file port steering
  assign rf_rd_addr1 = (sel == idc_pkg::SEL_MULT) ? mult_rd_addr1 : add_rd_addr1;
  assign rf_rd_addr2 = (sel == idc_pkg::SEL_MULT) ? mult_rd_addr2 : add_rd_addr2;
  assign rf_wr_en    = (sel == idc_pkg::SEL_MULT) ? mult_wr_en    : add_wr_en;
  assign rf_wr_addr  = (sel == idc_pkg::SEL_MULT) ? mult_wr_addr  : add_wr_addr;
  assign rf_wr_data  = (sel == idc_pkg::SEL_MULT) ? mult_wr_data  : add_wr_data;

  // Dispatched unit must stay busy until its done cycle
  a_unit_active: assert property (
    @(posedge clk) disable iff (rst)
    (state == idc_pkg::WAIT_UNIT) |-> (unit_busy || unit_done)
  ) else $error("decode_ctrl: selected unit idle while waiting");

endmodule

//--- idc_core.f
+incdir+.
idc_pkg.sv
reg_file.sv
add_unit.sv
mult_unit.sv
decode_ctrl.sv
idc_core.sv
tb_idc_core.sv

//--- idc_core.sv
`timescale 1ns/1ns

module idc_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  idc_pkg::instr_t    instruction,
  output logic               busy,
  output logic               done,
  output logic               fetch_stage_enable,
  output idc_pkg::pc_t       next_pc_to_cpu,
  output logic               wb_en,
  output idc_pkg::reg_addr_t wb_addr,
  output idc_pkg::data_t     wb_data
);

  // Controller to units
  logic               start_add, start_mult;
  idc_pkg::op_type_t  op_type;
  idc_pkg::reg_addr_t src1_addr, src2_addr, dst_addr;
  idc_pkg::data_t     imm;
  idc_pkg::pc_t       pc;

  // Units back to controller
  logic               add_busy, add_done, mult_busy, mult_done;
  idc_pkg::pc_t       add_next_pc, mult_next_pc;
  idc_pkg::reg_addr_t add_rd_addr1, add_rd_addr2, mult_rd_addr1, mult_rd_addr2;
  logic               add_wr_en, mult_wr_en;
  idc_pkg::reg_addr_t add_wr_addr, mult_wr_addr;
  idc_pkg::data_t     add_wr_data, mult_wr_data;

  // Register file read side, data fans out to both units
  idc_pkg::reg_addr_t rf_rd_addr1, rf_rd_addr2;
  idc_pkg::data_t     rf_rd_data1, rf_rd_data2;

  decode_ctrl u_ctrl (
    .clk, .rst, .start, .instruction,
    .busy, .done, .fetch_stage_enable, .next_pc_to_cpu,
    .start_add, .start_mult, .op_type, .src1_addr, .src2_addr, .dst_addr, .imm, .pc,
    .add_busy, .add_done, .mult_busy, .mult_done, .add_next_pc, .mult_next_pc,
    .add_rd_addr1, .add_rd_addr2, .mult_rd_addr1, .mult_rd_addr2,
    .add_wr_en, .mult_wr_en, .add_wr_addr, .mult_wr_addr, .add_wr_data, .mult_wr_data,
    .rf_rd_addr1, .rf_rd_addr2,
    .rf_wr_addr (wb_addr),  // Write port doubles as the write-back bus
    .rf_wr_en   (wb_en),
    .rf_wr_data (wb_data)
  );

  add_unit u_add (
    .clk, .rst, .start (start_add), .op_type, .src1_addr, .src2_addr, .dst_addr, .imm, .pc,
    .rd_addr1 (add_rd_addr1), .rd_addr2 (add_rd_addr2),
    .rd_data1 (rf_rd_data1),  .rd_data2 (rf_rd_data2),
    .wr_en (add_wr_en), .wr_addr (add_wr_addr), .wr_data (add_wr_data),
    .next_pc (add_next_pc), .busy (add_busy), .done (add_done)
  );

  mult_unit u_mult (
    .clk, .rst, .start (start_mult), .op_type, .src1_addr, .src2_addr, .dst_addr, .imm, .pc,
    .rd_addr1 (mult_rd_addr1), .rd_addr2 (mult_rd_addr2),
    .rd_data1 (rf_rd_data1),   .rd_data2 (rf_rd_data2),
    .wr_en (mult_wr_en), .wr_addr (mult_wr_addr), .wr_data (mult_wr_data),
    .next_pc (mult_next_pc), .busy (mult_busy), .done (mult_done)
  );

  reg_file u_rf (
    .clk, .rst,
    .rd_addr1 (rf_rd_addr1), .rd_addr2 (rf_rd_addr2),
    .wr_addr  (wb_addr), .wr_en (wb_en), .wr_data (wb_data),
    .rd_data1 (rf_rd_data1), .rd_data2 (rf_rd_data2)
  );

endmodule

//--- idc_defs.svh
`ifndef IDC_DEFS_SVH
`define IDC_DEFS_SVH

// Widths
`define IDC_INSTR_W   59
`define IDC_DATA_W    32
`define IDC_ADDR_W    5
`define IDC_PC_W      5
`define IDC_NUM_REGS  32

// Instruction field positions, MSB first
`define IDC_OPTYPE_HI 58
`define IDC_OPTYPE_LO 57
`define IDC_OPCODE_HI 56
`define IDC_OPCODE_LO 52
`define IDC_DST_HI    51
`define IDC_DST_LO    47
`define IDC_SRC1_HI   46
`define IDC_SRC1_LO   42
`define IDC_SRC2_HI   41
`define IDC_SRC2_LO   37
`define IDC_PC_HI     36
`define IDC_PC_LO     32
`define IDC_IMM_HI    31
`define IDC_IMM_LO    0

// Opcodes
`define IDC_OP_ADD    5'd0
`define IDC_OP_MULT   5'd1

// Operation types, anything else is treated as R
`define IDC_OPTYPE_R  2'd0
`define IDC_OPTYPE_I  2'd1

`endif

//--- idc_pkg.sv
`include "idc_defs.svh"

package idc_pkg;

  typedef logic [`IDC_INSTR_W-1:0] instr_t;    // Full instruction word
  typedef logic [`IDC_DATA_W-1:0]  data_t;     // Register or immediate value
  typedef logic [`IDC_ADDR_W-1:0]  reg_addr_t; // Register file index
  typedef logic [`IDC_PC_W-1:0]    pc_t;       // Program counter

  // Opcode and operation type fields
  typedef logic [`IDC_OPCODE_HI-`IDC_OPCODE_LO:0] opcode_t;
  typedef logic [`IDC_OPTYPE_HI-`IDC_OPTYPE_LO:0] op_type_t;

  // Top level decode FSM
  typedef enum logic [1:0] {
    IDLE      = 2'd0, // Waiting for start
    DISPATCH  = 2'd1, // Kick the selected unit
    WAIT_UNIT = 2'd2  // Unit is running
  } ctrl_state_t;

  // Shared by the add and multiply sub-controllers
  typedef enum logic [1:0] {
    U_IDLE = 2'd0,
    U_EXEC = 2'd1,
    U_DONE = 2'd2  // Write-back cycle
  } unit_state_t;

  // Which unit owns the register file ports
  typedef enum logic {
    SEL_ADD  = 1'b0,
    SEL_MULT = 1'b1
  } unit_sel_t;

endpackage

//--- mult_unit.sv
`timescale 1ns/1ns
`include "idc_defs.svh"

module mult_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  idc_pkg::op_type_t  op_type,
  input  idc_pkg::reg_addr_t src1_addr,
  input  idc_pkg::reg_addr_t src2_addr,
  input  idc_pkg::reg_addr_t dst_addr,
  input  idc_pkg::data_t     imm,
  input  idc_pkg::pc_t       pc,
  output idc_pkg::reg_addr_t rd_addr1,
  output idc_pkg::reg_addr_t rd_addr2,
  input  idc_pkg::data_t     rd_data1,
  input  idc_pkg::data_t     rd_data2,
  output logic               wr_en,
  output idc_pkg::reg_addr_t wr_addr,
  output idc_pkg::data_t     wr_data,
  output idc_pkg::pc_t       next_pc,
  output logic               busy,
  output logic               done
);

  localparam int CNT_W = $clog2(`IDC_DATA_W);

  idc_pkg::unit_state_t state;
  logic                 loaded;  // Operands captured, iterating
  logic [CNT_W-1:0]     cnt;     // Iteration count
  idc_pkg::op_type_t    op_type_q;
  idc_pkg::reg_addr_t   src1_q;
  idc_pkg::reg_addr_t   src2_q;
  idc_pkg::reg_addr_t   dst_q;
  idc_pkg::data_t       imm_q;
  idc_pkg::pc_t         pc_q;
  idc_pkg::data_t       operand_b;
  idc_pkg::data_t       mcand;   // Shifts left each step
  idc_pkg::data_t       mplier;  // Shifts right each step
  idc_pkg::data_t       acc;     // Low half of the product

  assign operand_b = (op_type_q == `IDC_OPTYPE_I) ? imm_q : rd_data2;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= idc_pkg::U_IDLE;
      loaded <= 1'b0;
      cnt    <= '0;
    end else begin
      case (state)
        idc_pkg::U_IDLE: begin
          if (start) begin
            state  <= idc_pkg::U_EXEC;
            loaded <= 1'b0;
            cnt    <= '0;
          end
        end
        idc_pkg::U_EXEC: begin
          if (!loaded) begin
            loaded <= 1'b1;                          // First cycle only captures
          end else begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(`IDC_DATA_W - 1)) begin
              state <= idc_pkg::U_DONE;              // Last step lands in acc
            end
          end
        end
        idc_pkg::U_DONE: state <= idc_pkg::U_IDLE;
        default:         state <= idc_pkg::U_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start) begin
      op_type_q <= op_type;
      src1_q    <= src1_addr;
      src2_q    <= src2_addr;
      dst_q     <= dst_addr;
      imm_q     <= imm;
      pc_q      <= pc;
    end
    if (state == idc_pkg::U_EXEC) begin
      if (!loaded) begin
        mcand  <= rd_data1;
        mplier <= operand_b;
        acc    <= '0;
      end else begin
        if (mplier[0]) acc <= acc + mcand;  // Bits above 31 drop out
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

  assign rd_addr1 = src1_q;
  assign rd_addr2 = src2_q;
  assign wr_en    = (state == idc_pkg::U_DONE);
  assign wr_addr  = dst_q;
  assign wr_data  = acc;
  assign next_pc  = pc_q + 5'd1;
  assign busy     = (state == idc_pkg::U_EXEC);
  assign done     = (state == idc_pkg::U_DONE);

  // A start outside U_IDLE would be dropped
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    start |-> (state == idc_pkg::U_IDLE)
  ) else $error("mult_unit: start while not idle");

endmodule

//--- reg_file.sv
`timescale 1ns/1ns
`include "idc_defs.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  idc_pkg::reg_addr_t rd_addr1,
  input  idc_pkg::reg_addr_t rd_addr2,
  input  idc_pkg::reg_addr_t wr_addr,
  input  logic              wr_en,
  input  idc_pkg::data_t     wr_data,
  output idc_pkg::data_t     rd_data1,
  output idc_pkg::data_t     rd_data2
);

  idc_pkg::data_t regs [`IDC_NUM_REGS]; // Scratchpad shared by all units

  // Whole array starts from zero so the CPU sees known values
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `IDC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data; // Single write port
    end
  end

  // Reads are combinational, new data visible the cycle after a write
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

  // A unit must never write back garbage
  a_wr_data_known: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> !$isunknown(wr_data)
  ) else $error("reg_file: unknown write data to r%0d", wr_addr);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_idc_core \
  -f idc_core.f \
  -o sim_idc

./obj_dir/sim_idc | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"

//--- tb_idc_core.sv
`timescale 1ns/1ns
`include "idc_defs.svh"

module tb_idc_core;

  typedef struct packed {
    logic [4:0]  opcode;
    logic [1:0]  op_type;
    logic [4:0]  dst;
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [4:0]  pc;
    logic [31:0] imm;
    logic        poke;    // Second start while busy
  } row_t;

  logic               clk;
  logic               rst;
  logic               start;
  idc_pkg::instr_t    instruction;
  logic               busy;
  logic               done;
  logic               fetch_stage_enable;
  idc_pkg::pc_t       next_pc_to_cpu;
  logic               wb_en;
  idc_pkg::reg_addr_t wb_addr;
  idc_pkg::data_t     wb_data;

  logic [31:0] model [`IDC_NUM_REGS]; // Expected register contents
  row_t        rows [$];
  string       names [$];
  int          err_cnt;
  int          timeout_cnt;
  int          wb_cnt;                // Write-back strobes seen so far
  logic [4:0]  wb_last_addr;
  logic [31:0] wb_last_data;
  logic        aborted;

  idc_core uut (
    .clk, .rst, .start, .instruction,
    .busy, .done, .fetch_stage_enable, .next_pc_to_cpu,
    .wb_en, .wb_addr, .wb_data
  );

  always #5 clk = ~clk;

  // Write-back monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && wb_en) begin
      wb_cnt       = wb_cnt + 1;
      wb_last_addr = wb_addr;
      wb_last_data = wb_data;
    end
  end

  function automatic idc_pkg::instr_t build_instr(row_t r);
    idc_pkg::instr_t w;
    w = '0;
    w[`IDC_OPTYPE_HI:`IDC_OPTYPE_LO] = r.op_type;
    w[`IDC_OPCODE_HI:`IDC_OPCODE_LO] = r.opcode;
    w[`IDC_DST_HI:`IDC_DST_LO]       = r.dst;
    w[`IDC_SRC1_HI:`IDC_SRC1_LO]     = r.src1;
    w[`IDC_SRC2_HI:`IDC_SRC2_LO]     = r.src2;
    w[`IDC_PC_HI:`IDC_PC_LO]         = r.pc;
    w[`IDC_IMM_HI:`IDC_IMM_LO]       = r.imm;
    return w;
  endfunction

  // Sum or low half of the product, from the model registers
  function automatic logic [31:0] expect_result(row_t r);
    logic [31:0] b;
    logic [63:0] prod;
    b = (r.op_type == `IDC_OPTYPE_I) ? r.imm : model[r.src2]; // Types 2 and 3 act as R
    prod = {32'd0, model[r.src1]} * {32'd0, b};
    if (r.opcode == `IDC_OP_MULT) return prod[31:0];
    return model[r.src1] + b;
  endfunction

  task automatic push_row(string name, logic [4:0] opcode, logic [1:0] op_type, int dst,
                          int src1, int src2, int pc, logic [31:0] imm, logic poke);
    row_t r;
    r.opcode  = opcode;
    r.op_type = op_type;
    r.dst     = 5'(dst);
    r.src1    = 5'(src1);
    r.src2    = 5'(src2);
    r.pc      = 5'(pc);
    r.imm     = imm;
    r.poke    = poke;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic wait_done(string name);
    int n;
    n = 0;
    while (!done && n < 200) begin
      @(negedge clk);
      n++;
    end
    assert (done) else begin
      $display("Test %s never raised done within 200 cycles", name);
      timeout_cnt++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_idle(string name);
    int n;
    n = 0;
    while (busy && n < 200) begin
      @(negedge clk);
      n++;
    end
    assert (!busy) else begin
      $display("Test %s left busy high for 200 cycles", name);
      timeout_cnt++;
      aborted = 1'b1;
    end
  endtask

  task automatic run_row(int i);
    row_t        r;
    row_t        alt;
    string       name;
    logic [31:0] exp_data;
    logic [4:0]  exp_pc;
    logic        writes;
    int          wb_before;
    r         = rows[i];
    name      = names[i];
    writes    = (r.opcode == `IDC_OP_ADD) || (r.opcode == `IDC_OP_MULT);
    exp_data  = expect_result(r);
    exp_pc    = 5'((int'(r.pc) + 1) % 32);
    wb_before = wb_cnt;
    @(posedge clk);
    start       <= 1'b1;
    instruction <= build_instr(r);
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value(name, "busy after start", 32'd1, 32'(busy));
    check_value(name, "done after start", 32'd0, 32'(done));
    check_value(name, "fetch enable after start", 32'd0, 32'(fetch_stage_enable));
    if (r.poke) begin
      alt     = r;
      alt.dst = r.dst ^ 5'h1f;            // Would land elsewhere if accepted
      alt.imm = ~r.imm;
      repeat (4) @(posedge clk);
      start       <= 1'b1;
      instruction <= build_instr(alt);
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_value(name, "busy during second start", 32'd1, 32'(busy));
    end
    wait_done(name);
    if (!aborted) begin
      check_value(name, "busy at done", 32'd0, 32'(busy));
      check_value(name, "fetch enable at done", 32'd1, 32'(fetch_stage_enable));
      check_value(name, "next pc", 32'(exp_pc), 32'(next_pc_to_cpu));
      check_value(name, "write-back count", writes ? 32'd1 : 32'd0, 32'(wb_cnt - wb_before));
      if (writes) begin
        check_value(name, "wb_addr", 32'(r.dst), 32'(wb_last_addr));
        check_value(name, "wb_data", exp_data, wb_last_data);
        model[r.dst] = exp_data;
      end
      if (r.poke) begin
        repeat (4) @(negedge clk);          // Ignored start must not run late
        check_value(name, "write-backs after second start", 32'd1, 32'(wb_cnt - wb_before));
        check_value(name, "busy after second start", 32'd0, 32'(busy));
      end
      wait_idle(name);
    end
  endtask

  initial begin
    int k;
    int sel;
    logic [4:0] opc;
    void'($urandom(32'h3f2cac1e));
    clk         = 1'b0;
    rst         = 1'b1;
    start       = 1'b0;
    instruction = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    wb_cnt      = 0;
    aborted     = 1'b0;
    for (k = 0; k < `IDC_NUM_REGS; k++) model[k] = '0;

    // Seed values, then chains that read earlier results back
    push_row("add_i_fresh", `IDC_OP_ADD, `IDC_OPTYPE_I, 1, 0, 0, 3, 32'h1234_5678, 1'b0);
    push_row("add_i_seed", `IDC_OP_ADD, `IDC_OPTYPE_I, 2, 0, 0, 4, 32'hffff_fff0, 1'b0);
    push_row("add_i_wrap", `IDC_OP_ADD, `IDC_OPTYPE_I, 3, 2, 0, 5, 32'h0000_0025, 1'b0);
    push_row("add_r", `IDC_OP_ADD, `IDC_OPTYPE_R, 4, 1, 2, 6, 32'hdead_beef, 1'b0);
    push_row("mult_r", `IDC_OP_MULT, `IDC_OPTYPE_R, 5, 1, 3, 7, 32'h0, 1'b0);
    push_row("mult_i", `IDC_OP_MULT, `IDC_OPTYPE_I, 6, 2, 0, 8, 32'h0000_0007, 1'b0);
    push_row("mult_r_chain", `IDC_OP_MULT, `IDC_OPTYPE_R, 7, 5, 6, 9, 32'h0, 1'b0);
    push_row("add_type3_as_r", `IDC_OP_ADD, 2'd3, 8, 7, 4, 10, 32'h1, 1'b0);
    push_row("add_i_self", `IDC_OP_ADD, `IDC_OPTYPE_I, 1, 1, 0, 11, 32'h1, 1'b0);
    push_row("add_r_pc_wrap", `IDC_OP_ADD, `IDC_OPTYPE_R, 9, 8, 1, 31, 32'h0, 1'b0);
    push_row("mult_i_pc_wrap", `IDC_OP_MULT, `IDC_OPTYPE_I, 10, 9, 0, 31, 32'h8000_0001, 1'b0);
    push_row("unknown_op", 5'd7, `IDC_OPTYPE_R, 11, 1, 2, 12, 32'h0, 1'b0);
    push_row("unknown_op_pc_wrap", 5'd31, `IDC_OPTYPE_I, 12, 1, 2, 31, 32'h5, 1'b0);
    push_row("mult_second_start", `IDC_OP_MULT, `IDC_OPTYPE_R, 13, 10, 7, 20, 32'h0, 1'b1);
    push_row("readback_r13", `IDC_OP_ADD, `IDC_OPTYPE_I, 14, 13, 0, 21, 32'h0, 1'b0);

    // Random rows, roughly a quarter with unknown opcodes
    for (k = 0; k < 20; k++) begin
      sel = $urandom % 4;
      opc = (sel == 1) ? `IDC_OP_MULT : (sel == 3) ? 5'(2 + $urandom % 30) : `IDC_OP_ADD;
      push_row($sformatf("rand_%0d", k), opc, 2'($urandom % 4), $urandom % 32,
               $urandom % 32, $urandom % 32, $urandom % 32, $urandom, 1'b0);
    end

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset", "busy", 32'd0, 32'(busy));
    check_value("reset", "done", 32'd0, 32'(done));
    check_value("reset", "fetch enable", 32'd0, 32'(fetch_stage_enable));
    check_value("reset", "next pc", 32'd0, 32'(next_pc_to_cpu));

    for (k = 0; k < rows.size(); k++) begin
      run_row(k);
      if (aborted) break;
    end

    $display("Errors: %0d value mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
